//--- tb.f
+incdir+tb
rtl/mac_glue_pkg.sv
rtl/reset_sequencer.sv
rtl/bus_ack_decoder.sv
rtl/rom_download_writer.sv
rtl/memory_port_mux.sv
rtl/floppy_status.sv
rtl/mac_glue_top.sv
tb/tb_mac_glue.sv

//--- Bender.yml
package:
  name: mac_glue

sources:
  - rtl/mac_glue_pkg.sv
  - rtl/reset_sequencer.sv
  - rtl/bus_ack_decoder.sv
  - rtl/rom_download_writer.sv
  - rtl/memory_port_mux.sv
  - rtl/floppy_status.sv
  - rtl/mac_glue_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_mac_glue.sv

//--- tb/tb_mac_glue_tasks.svh
/*
 * Directed tests of the glue logic, cycle helpers and
 * compare tasks for bits, bit pairs, words and SDRAM addresses
 */

`ifndef TB_MAC_GLUE_TASKS_SVH
`define TB_MAC_GLUE_TASKS_SVH

// ==========================================================
// Compare tasks
// ==========================================================
task automatic compare_bit(input string name, input logic got, input logic exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("CHECK FAILED at time %0t: %s = %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic compare_pair(input string name, input logic [1:0] got,
	input logic [1:0] exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("CHECK FAILED at time %0t: %s = %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic compare_word(input string name, input mac_word_t got, input mac_word_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("CHECK FAILED at time %0t: %s = %h, expected %h", $time, name, got, exp);
	end
endtask

// Shows the address in both views
task automatic compare_addr(input string name, input sdram_addr_u got,
	input sdram_addr_u exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("CHECK FAILED at time %0t: %s = dl(bank %h target %h) cpu(rom %b word %h),",
			$time, name, got.dl.bank, got.dl.target, got.cpu.rom, got.cpu.word);
		$display("  expected dl(bank %h target %h) cpu(rom %b word %h)",
			exp.dl.bank, exp.dl.target, exp.cpu.rom, exp.cpu.word);
	end
endtask

// ==========================================================
// Cycle helpers
// ==========================================================
// Back to the drive point just after the next rising edge
task automatic step_cycle();
	@(posedge clk_sys);
	#1;
endtask

task automatic wait_strobe();
	@(posedge clk_sys);
	while (!clk8_en_p) @(posedge clk_sys);
	#1;
endtask

// n_reset low for 15 strobes, high on the 16th
task automatic reset_hold_count(input string cause);
	for (int i = 1; i <= 15; i++) begin
		wait_strobe();
		compare_bit($sformatf("n_reset after %s, strobe %0d", cause, i), n_reset, 1'b0);
	end
	wait_strobe();
	compare_bit($sformatf("n_reset after %s, strobe 16", cause), n_reset, 1'b1);
endtask

task automatic wait_ioctl_release(input int max_cycles);
	int n;
	n = 0;
	while (ioctl_wait && n < max_cycles) begin
		step_cycle();
		n++;
	end
	check_count++;
	if (ioctl_wait) begin
		error_count++;
		$display("ioctl_wait still high %0d cycles after the download slot ended",
			max_cycles);
	end
endtask

// One download of the given size, ending with dio_download low
task automatic end_download(input logic [7:0] index, input int words);
	dio_index    = index;
	ioctl_addr   = 25'(words * 2);
	dio_download = 1'b1;
	step_cycle();
	dio_download = 1'b0;
	step_cycle();
	ioctl_addr = '0;
	dio_index  = 8'd0;
endtask

// ==========================================================
// Directed tests
// ==========================================================
task automatic state_after_reset();
	compare_bit("n_reset", n_reset, 1'b0);
	compare_bit("ioctl_wait", ioctl_wait, 1'b0);
	compare_bit("led_user", led_user, 1'b0);
	compare_pair("disk_inserted", disk_inserted, 2'b00);
	compare_pair("disk_double_sided", disk_double_sided, 2'b00);
	compare_bit("cpu_dtack_n", cpu_dtack_n, 1'b1);
	compare_bit("cpu_vpa_n", cpu_vpa_n, 1'b1);
endtask

task automatic reset_hold_sequence();
	user_button = 1'b1;
	wait_strobe();
	user_button = 1'b0;
	reset_hold_count("user_button");
	repeat (5) wait_strobe();
	// Memory size change restarts the hold
	status_mem = 1'b1;
	wait_strobe();
	compare_bit("n_reset at status_mem change", n_reset, 1'b0);
	reset_hold_count("status_mem change");
endtask

task automatic bus_ack_cycles();
	// Peripheral space
	cpu_addr = {3'b111, 20'h00abc};
	cpu_fc   = 3'b101;
	cpu_as_n = 1'b0;
	#1;
	compare_bit("cpu_vpa_n in I/O space", cpu_vpa_n, 1'b0);
	compare_bit("cpu_dtack_n in I/O space", cpu_dtack_n, 1'b1);
	cpu_as_n = 1'b1;
	cpu_fc   = 3'b111;
	#1;
	compare_bit("cpu_vpa_n at interrupt ack", cpu_vpa_n, 1'b0);
	compare_bit("cpu_dtack_n at interrupt ack", cpu_dtack_n, 1'b1);
	step_cycle();
	// Memory cycle without turbo
	cpu_fc     = 3'b110;
	cpu_addr   = {3'b000, 20'($random(seed))};
	select_ram = 1'b1;
	cpu_as_n   = 1'b0;
	#1;
	compare_bit("cpu_vpa_n in memory", cpu_vpa_n, 1'b1);
	compare_bit("cpu_dtack_n in memory", cpu_dtack_n, 1'b0);
	step_cycle();
	cpu_as_n     = 1'b1;
	status_turbo = 1'b1;
	select_ram   = 1'b0;
	select_rom   = 1'b1;
	step_cycle();
	// Turbo waits for the bus slot
	cpu_as_n = 1'b0;
	repeat (3) begin
		step_cycle();
		compare_bit("cpu_dtack_n before slot", cpu_dtack_n, 1'b1);
	end
	cpu_bus_control = 1'b1;
	#1;
	compare_bit("cpu_dtack_n at slot start", cpu_dtack_n, 1'b1);
	step_cycle();
	compare_bit("cpu_dtack_n after slot start", cpu_dtack_n, 1'b0);
	cpu_as_n = 1'b1;
	step_cycle();
	compare_bit("cpu_dtack_n after cpu_as_n rise", cpu_dtack_n, 1'b1);
	cpu_as_n = 1'b0;
	#1;
	compare_bit("cpu_dtack_n in next cycle", cpu_dtack_n, 1'b1);
	step_cycle();
	compare_bit("cpu_dtack_n without new slot", cpu_dtack_n, 1'b1);
	cpu_as_n        = 1'b1;
	status_turbo    = 1'b0;
	cpu_bus_control = 1'b0;
	select_rom      = 1'b0;
	cpu_fc          = 3'd0;
	step_cycle();
endtask

task automatic download_word_write();
	mac_word_t   word;
	logic [18:0] offset;
	sdram_addr_u exp_addr;
	word            = 16'($random(seed));
	offset          = 19'($random(seed));
	dio_download    = 1'b1;
	dio_index       = 8'd1;
	ioctl_addr      = {5'b00000, offset, 1'b0};
	ioctl_data      = word;
	ioctl_write     = 1'b1;
	step_cycle();
	ioctl_write = 1'b0;
	compare_bit("ioctl_wait after write", ioctl_wait, 1'b1);
	step_cycle();
	dio_bus_control = 1'b1;
	#1;
	exp_addr.dl.bank   = 4'd1;
	exp_addr.dl.target = {2'b01, offset};
	compare_addr("sdram_addr in download slot", sdram_addr, exp_addr);
	compare_word("sdram_din in download slot", sdram_din, {word[7:0], word[15:8]});
	compare_word("sdram_do in download slot", sdram_do, 16'hffff);
	compare_bit("sdram_we in download slot", sdram_we, 1'b1);
	compare_bit("sdram_oe in download slot", sdram_oe, 1'b0);
	compare_pair("sdram_ds in download slot", sdram_ds, 2'b11);
	step_cycle();
	compare_bit("ioctl_wait inside slot", ioctl_wait, 1'b1);
	dio_bus_control = 1'b0;
	wait_ioctl_release(8);
	// Zero size keeps drive 1 empty when the download ends
	ioctl_addr   = '0;
	dio_download = 1'b0;
	step_cycle();
	step_cycle();
	dio_index = 8'd0;
endtask

task automatic cpu_memory_access();
	mem_addr_t   addr;
	mac_word_t   data;
	mac_word_t   rd;
	sdram_addr_u exp_addr;
	addr            = 22'($random(seed));
	data            = 16'($random(seed));
	rom_oe_n        = 1'b0;
	memory_uds_n    = 1'b0;
	memory_lds_n    = 1'b1;
	memory_addr     = addr;
	memory_data_out = data;
	#1;
	exp_addr          = '0;
	exp_addr.cpu.rom  = 1'b1;
	exp_addr.cpu.word = addr[21:1];
	compare_addr("sdram_addr for ROM read", sdram_addr, exp_addr);
	compare_pair("sdram_ds for ROM read", sdram_ds, 2'b10);
	compare_bit("sdram_oe for ROM read", sdram_oe, 1'b1);
	compare_bit("sdram_we for ROM read", sdram_we, 1'b0);
	compare_word("sdram_din for ROM read", sdram_din, data);
	// Disk reads spread one byte over the word
	rd                = 16'($random(seed));
	sdram_out         = rd;
	rom_oe_n          = 1'b1;
	ram_oe_n          = 1'b0;
	memory_lds_n      = 1'b0;
	disk_read_ack_int = 1'b1;
	memory_addr       = {addr[21:1], 1'b1};
	#1;
	compare_word("sdram_do odd disk read", sdram_do, {rd[7:0], rd[7:0]});
	disk_read_ack_int = 1'b0;
	disk_read_ack_ext = 1'b1;
	memory_addr       = {addr[21:1], 1'b0};
	#1;
	compare_word("sdram_do even disk read", sdram_do, {rd[15:8], rd[15:8]});
	disk_read_ack_ext = 1'b0;
	#1;
	compare_word("sdram_do plain read", sdram_do, rd);
	ram_oe_n     = 1'b1;
	memory_uds_n = 1'b1;
	memory_lds_n = 1'b1;
	step_cycle();
endtask

task automatic floppy_image_detect();
	end_download(8'd1, 409600);
	end_download(8'd2, 204800);
	compare_pair("disk_inserted after two images", disk_inserted, 2'b11);
	compare_pair("disk_double_sided after two images", disk_double_sided, 2'b01);
	end_download(8'd2, 1000);
	compare_pair("disk_inserted after odd size", disk_inserted, 2'b01);
	compare_pair("disk_double_sided after odd size", disk_double_sided, 2'b01);
	disk_eject = 2'b01;
	step_cycle();
	disk_eject = 2'b00;
	compare_pair("disk_inserted after eject", disk_inserted, 2'b00);
	compare_pair("disk_double_sided after eject", disk_double_sided, 2'b00);
endtask

task automatic activity_led_timing();
	step_cycle();
	compare_bit("led_user idle", led_user, 1'b0);
	disk_act = 2'b01;
	step_cycle();
	disk_act = 2'b00;
	step_cycle();
	compare_bit("led_user after activity", led_user, 1'b1);
	repeat (23) step_cycle();
	compare_bit("led_user 25 cycles later", led_user, 1'b0);
	disk_motor = 2'b10;
	#1;
	compare_bit("led_user with motor on", led_user, 1'b1);
	disk_motor   = 2'b00;
	dio_download = 1'b1;
	#1;
	compare_bit("led_user during download", led_user, 1'b1);
	dio_download = 1'b0;
	step_cycle();
	step_cycle();
	compare_bit("led_user after download", led_user, 1'b0);
endtask

`endif

//--- tb/tb_mac_glue.sv
/*
 * Testbench top for the Mac Plus glue logic:
 * clock, 8 MHz strobe, reset, DUT instance, watchdog
 * and the directed test sequence
 */

`timescale 1ns/1ps

module tb_mac_glue;
	import mac_glue_pkg::*;

	localparam int CLK_PERIOD = 4;

	// Cycle budget of each test, the watchdog allows twice the sum
	localparam int STATE_CYCLES  = 100;
	localparam int HOLD_CYCLES   = 1200;
	localparam int ACK_CYCLES    = 300;
	localparam int DL_CYCLES     = 300;
	localparam int CPU_CYCLES    = 200;
	localparam int FLOPPY_CYCLES = 200;
	localparam int LED_CYCLES    = 200;
	localparam int TEST_CYCLES   = STATE_CYCLES + HOLD_CYCLES + ACK_CYCLES +
		DL_CYCLES + CPU_CYCLES + FLOPPY_CYCLES + LED_CYCLES;
	localparam int WATCHDOG_NS   = 2 * TEST_CYCLES * CLK_PERIOD;

	// DUT inputs
	logic        clk_sys;
	logic        reset;
	logic        clk8_en_p;
	logic        pll_locked;
	logic        status_reset;
	logic        user_button;
	logic        status_mem;
	logic        status_turbo;
	logic        cpu_reset_n;
	logic        cpu_reset_out_n;
	logic        cpu_as_n;
	logic [2:0]  cpu_fc;
	cpu_addr_t   cpu_addr;
	logic        cpu_bus_control;
	logic        select_rom;
	logic        select_ram;
	logic        dio_download;
	logic [7:0]  dio_index;
	logic        ioctl_write;
	logic [24:0] ioctl_addr;
	mac_word_t   ioctl_data;
	logic        dio_bus_control;
	logic        rom_oe_n;
	logic        ram_oe_n;
	logic        ram_we_n;
	logic        memory_uds_n;
	logic        memory_lds_n;
	mem_addr_t   memory_addr;
	mac_word_t   memory_data_out;
	mac_word_t   sdram_out;
	logic        disk_read_ack_int;
	logic        disk_read_ack_ext;
	logic [1:0]  disk_eject;
	logic [1:0]  disk_act;
	logic [1:0]  disk_motor;

	// DUT outputs
	logic        n_reset;
	logic        cpu_vpa_n;
	logic        cpu_dtack_n;
	logic        ioctl_wait;
	sdram_addr_u sdram_addr;
	mac_word_t   sdram_din;
	logic [1:0]  sdram_ds;
	logic        sdram_we;
	logic        sdram_oe;
	mac_word_t   sdram_do;
	logic [1:0]  disk_inserted;
	logic [1:0]  disk_double_sided;
	logic        led_user;

	integer      seed;
	int          check_count;
	int          error_count;
	logic [1:0]  strobe_phase;

	mac_glue_top #(
		.RESET_CNT_W(4),
		.ACT_HOLD   (20)
	) u_mac_glue_top (.*);

	`include "tb_mac_glue_tasks.svh"

	// ==========================================================
	// Clock and 8 MHz strobe
	// ==========================================================
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// One strobe every fourth cycle
	always @(posedge clk_sys) begin
		#1;
		strobe_phase = strobe_phase + 2'd1;
		clk8_en_p    = (strobe_phase == 2'd3);
	end

	// ==========================================================
	// Watchdog
	// ==========================================================
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the test sequence did not finish",
			WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ==========================================================
	// Test sequence
	// ==========================================================
	initial begin
		seed              = 72;
		check_count       = 0;
		error_count       = 0;
		strobe_phase      = 2'd0;
		clk_sys           = 1'b0;
		clk8_en_p         = 1'b0;
		reset             = 1'b1;
		pll_locked        = 1'b1;
		status_reset      = 1'b0;
		user_button       = 1'b0;
		status_mem        = 1'b0;
		status_turbo      = 1'b0;
		cpu_reset_n       = 1'b1;
		cpu_reset_out_n   = 1'b1;
		cpu_as_n          = 1'b1;
		cpu_fc            = 3'd0;
		cpu_addr          = '0;
		cpu_bus_control   = 1'b0;
		select_rom        = 1'b0;
		select_ram        = 1'b0;
		dio_download      = 1'b0;
		dio_index         = 8'd0;
		ioctl_write       = 1'b0;
		ioctl_addr        = '0;
		ioctl_data        = '0;
		dio_bus_control   = 1'b0;
		rom_oe_n          = 1'b1;
		ram_oe_n          = 1'b1;
		ram_we_n          = 1'b1;
		memory_uds_n      = 1'b1;
		memory_lds_n      = 1'b1;
		memory_addr       = '0;
		memory_data_out   = '0;
		sdram_out         = '0;
		disk_read_ack_int = 1'b0;
		disk_read_ack_ext = 1'b0;
		disk_eject        = 2'b00;
		disk_act          = 2'b00;
		disk_motor        = 2'b00;

		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		state_after_reset();
		reset_hold_sequence();
		bus_ack_cycles();
		download_word_write();
		cpu_memory_access();
		floppy_image_detect();
		activity_led_timing();

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/mac_glue_top.sv
/*
 * Glue logic top level around the Mac Plus CPU and memory:
 * reset sequencer, bus acknowledge, download writer,
 * SDRAM port mux and floppy status
 */

`timescale 1ns/1ps

module mac_glue_top #(
	parameter int RESET_CNT_W = 16,
	parameter int ACT_HOLD    = 500000
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    clk8_en_p,
	input  logic                    pll_locked,
	input  logic                    status_reset,
	input  logic                    user_button,
	input  logic                    status_mem,
	input  logic                    status_turbo,
	input  logic                    cpu_reset_n,
	input  logic                    cpu_reset_out_n,
	input  logic                    cpu_as_n,
	input  logic [2:0]              cpu_fc,
	input  mac_glue_pkg::cpu_addr_t cpu_addr,
	input  logic                    cpu_bus_control,
	input  logic                    select_rom,
	input  logic                    select_ram,
	input  logic                    dio_download,
	input  logic [7:0]              dio_index,
	input  logic                    ioctl_write,
	input  logic [24:0]             ioctl_addr,
	input  mac_glue_pkg::mac_word_t ioctl_data,
	input  logic                    dio_bus_control,
	input  logic                    rom_oe_n,
	input  logic                    ram_oe_n,
	input  logic                    ram_we_n,
	input  logic                    memory_uds_n,
	input  logic                    memory_lds_n,
	input  mac_glue_pkg::mem_addr_t memory_addr,
	input  mac_glue_pkg::mac_word_t memory_data_out,
	input  mac_glue_pkg::mac_word_t sdram_out,
	input  logic                    disk_read_ack_int,
	input  logic                    disk_read_ack_ext,
	input  logic [1:0]              disk_eject,
	input  logic [1:0]              disk_act,
	input  logic [1:0]              disk_motor,
	output logic                    n_reset,
	output logic                    cpu_vpa_n,
	output logic                    cpu_dtack_n,
	output logic                    ioctl_wait,
	output mac_glue_pkg::sdram_addr_u sdram_addr,
	output mac_glue_pkg::mac_word_t sdram_din,
	output logic [1:0]              sdram_ds,
	output logic                    sdram_we,
	output logic                    sdram_oe,
	output mac_glue_pkg::mac_word_t sdram_do,
	output logic [1:0]              disk_inserted,
	output logic [1:0]              disk_double_sided,
	output logic                    led_user
);
	import mac_glue_pkg::*;

	// Download word on its way to the SDRAM
	dl_addr_t  dl_addr;
	mac_word_t dl_data;
	logic      dl_write;

	reset_sequencer #(
		.RESET_CNT_W(RESET_CNT_W)
	) u_reset_sequencer (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.clk8_en_p       (clk8_en_p),
		.pll_locked      (pll_locked),
		.status_reset    (status_reset),
		.user_button     (user_button),
		.status_mem      (status_mem),
		.cpu_reset_out_n (cpu_reset_out_n),
		.n_reset         (n_reset)
	);

	bus_ack_decoder u_bus_ack_decoder (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cpu_reset_n     (cpu_reset_n),
		.status_turbo    (status_turbo),
		.cpu_as_n        (cpu_as_n),
		.cpu_fc          (cpu_fc),
		.cpu_addr        (cpu_addr),
		.cpu_bus_control (cpu_bus_control),
		.select_rom      (select_rom),
		.select_ram      (select_ram),
		.cpu_vpa_n       (cpu_vpa_n),
		.cpu_dtack_n     (cpu_dtack_n)
	);

	rom_download_writer u_rom_download_writer (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ioctl_write     (ioctl_write),
		.ioctl_addr      (ioctl_addr),
		.ioctl_data      (ioctl_data),
		.dio_index       (dio_index),
		.dio_bus_control (dio_bus_control),
		.ioctl_wait      (ioctl_wait),
		.dl_addr         (dl_addr),
		.dl_data         (dl_data),
		.dl_write        (dl_write)
	);

	memory_port_mux u_memory_port_mux (
		.dio_download      (dio_download),
		.dio_bus_control   (dio_bus_control),
		.dl_addr           (dl_addr),
		.dl_data           (dl_data),
		.dl_write          (dl_write),
		.rom_oe_n          (rom_oe_n),
		.ram_oe_n          (ram_oe_n),
		.ram_we_n          (ram_we_n),
		.memory_uds_n      (memory_uds_n),
		.memory_lds_n      (memory_lds_n),
		.memory_addr       (memory_addr),
		.memory_data_out   (memory_data_out),
		.sdram_out         (sdram_out),
		.disk_read_ack_int (disk_read_ack_int),
		.disk_read_ack_ext (disk_read_ack_ext),
		.sdram_addr        (sdram_addr),
		.sdram_din         (sdram_din),
		.sdram_ds          (sdram_ds),
		.sdram_we          (sdram_we),
		.sdram_oe          (sdram_oe),
		.sdram_do          (sdram_do)
	);

	floppy_status #(
		.ACT_HOLD(ACT_HOLD)
	) u_floppy_status (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.dio_download      (dio_download),
		.dio_index         (dio_index),
		.ioctl_addr        (ioctl_addr),
		.disk_eject        (disk_eject),
		.disk_act          (disk_act),
		.disk_motor        (disk_motor),
		.disk_inserted     (disk_inserted),
		.disk_double_sided (disk_double_sided),
		.led_user          (led_user)
	);

endmodule

//--- rtl/floppy_status.sv
/*
 * Floppy status, image type per drive from the download
 * size, eject handling and the disk activity LED
 */

`timescale 1ns/1ps

module floppy_status #(
	parameter int ACT_HOLD = 500000
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dio_download,
	input  logic [7:0]  dio_index,
	input  logic [24:0] ioctl_addr,
	input  logic [1:0]  disk_eject,
	input  logic [1:0]  disk_act,
	input  logic [1:0]  disk_motor,
	output logic [1:0]  disk_inserted,
	output logic [1:0]  disk_double_sided,
	output logic        led_user
);
	import mac_glue_pkg::*;

	localparam int ACT_W = $clog2(ACT_HOLD + 1);

	logic [23:0]      word_count;
	logic             download_d;
	logic             download_done;
	logic [1:0]       single_sided;
	logic [ACT_W-1:0] act_timer;
	logic             act_flag;

	// Address counts words, so it is the size once the download ends
	assign word_count    = ioctl_addr[24:1];
	assign download_done = download_d && !dio_download;

	// ==========================================================
	// Image type per drive
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d        <= 1'b0;
			disk_double_sided <= 2'b00;
			single_sided      <= 2'b00;
		end else begin
			download_d <= dio_download;
			for (int d = 0; d < 2; d++) begin
				if (download_done &&
					dio_index == 8'(d == 0 ? IDX_INT_FLOPPY : IDX_EXT_FLOPPY)) begin
					disk_double_sided[d] <= (word_count == 24'(DSK_DS_WORDS));
					single_sided[d]      <= (word_count == 24'(DSK_SS_WORDS));
				end
				// Eject wins over a download ending in the same cycle
				if (disk_eject[d]) begin
					disk_double_sided[d] <= 1'b0;
					single_sided[d]      <= 1'b0;
				end
			end
		end
	end

	assign disk_inserted = disk_double_sided | single_sided;

	// ==========================================================
	// Activity LED
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			act_timer <= '0;
			act_flag  <= 1'b0;
		end else begin
			act_flag <= (act_timer != '0);
			if (|disk_act) begin
				act_timer <= ACT_W'(ACT_HOLD);
			end else if (act_timer != '0) begin
				act_timer <= act_timer - 1'b1;
			end
		end
	end

	// A spinning motor inverts the LED, so activity blinks it off
	assign led_user = dio_download || (act_flag ^ |disk_motor);

endmodule

//--- rtl/memory_port_mux.sv
/*
 * SDRAM port multiplexer between the download path and the
 * CPU path, with the byte spread for floppy reads
 */

`timescale 1ns/1ps

module memory_port_mux (
	input  logic                      dio_download,
	input  logic                      dio_bus_control,
	input  mac_glue_pkg::dl_addr_t    dl_addr,
	input  mac_glue_pkg::mac_word_t   dl_data,
	input  logic                      dl_write,
	input  logic                      rom_oe_n,
	input  logic                      ram_oe_n,
	input  logic                      ram_we_n,
	input  logic                      memory_uds_n,
	input  logic                      memory_lds_n,
	input  mac_glue_pkg::mem_addr_t   memory_addr,
	input  mac_glue_pkg::mac_word_t   memory_data_out,
	input  mac_glue_pkg::mac_word_t   sdram_out,
	input  logic                      disk_read_ack_int,
	input  logic                      disk_read_ack_ext,
	output mac_glue_pkg::sdram_addr_u sdram_addr,
	output mac_glue_pkg::mac_word_t   sdram_din,
	output logic [1:0]                sdram_ds,
	output logic                      sdram_we,
	output logic                      sdram_oe,
	output mac_glue_pkg::mac_word_t   sdram_do
);
	import mac_glue_pkg::*;

	logic      download_cycle;
	logic      disk_read;
	mac_word_t disk_byte_word;

	assign download_cycle = dio_download && dio_bus_control;
	assign disk_read      = disk_read_ack_int || disk_read_ack_ext;

	// Floppy images are byte wide, odd address takes the low byte
	assign disk_byte_word = memory_addr[0] ? {sdram_out[7:0], sdram_out[7:0]} :
		{sdram_out[15:8], sdram_out[15:8]};

	always_comb begin
		if (download_cycle) begin
			sdram_addr.dl.bank   = DL_BANK_TAG;
			sdram_addr.dl.target = dl_addr;
			sdram_din            = dl_data;
			sdram_ds             = 2'b11;
			sdram_we             = dl_write;
			sdram_oe             = 1'b0;
			// Screen stays black while downloading
			sdram_do             = '1;
		end else begin
			sdram_addr.cpu.pad  = 3'b000;
			sdram_addr.cpu.rom  = !rom_oe_n;
			sdram_addr.cpu.word = memory_addr[21:1];
			sdram_din           = memory_data_out;
			sdram_ds            = {!memory_uds_n, !memory_lds_n};
			sdram_we            = !ram_we_n;
			sdram_oe            = !ram_oe_n || !rom_oe_n;
			sdram_do            = disk_read ? disk_byte_word : sdram_out;
		end
	end

endmodule

//--- rtl/rom_download_writer.sv
/*
 * ROM and disk download writer that buffers one host word,
 * swaps its bytes and writes it in the download bus slot
 */

`timescale 1ns/1ps

module rom_download_writer (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_write,
	input  logic [24:0]             ioctl_addr,
	input  mac_glue_pkg::mac_word_t ioctl_data,
	input  logic [7:0]              dio_index,
	input  logic                    dio_bus_control,
	output logic                    ioctl_wait,
	output mac_glue_pkg::dl_addr_t  dl_addr,
	output mac_glue_pkg::mac_word_t dl_data,
	output logic                    dl_write
);
	logic bus_control_d;
	logic slot_end;

	// Download slot just closed with a write pending
	assign slot_end = bus_control_d && !dio_bus_control && dl_write;

	// Host word buffer
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_data <= '0;
			dl_addr <= '0;
		end else if (ioctl_write) begin
			dl_data <= {ioctl_data[7:0], ioctl_data[15:8]};
			dl_addr <= {dio_index[1:0], ioctl_addr[19:1]};
		end
	end

	// ==========================================================
	// Wait handshake and write timing
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait    <= 1'b0;
			dl_write      <= 1'b0;
			bus_control_d <= 1'b0;
		end else begin
			bus_control_d <= dio_bus_control;
			if (ioctl_write) begin
				ioctl_wait <= 1'b1;
			end
			// Arm the write outside the slot so it is stable inside
			if (!dio_bus_control) begin
				dl_write <= ioctl_wait;
			end
			if (slot_end) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

endmodule

//--- rtl/bus_ack_decoder.sv
/*
 * CPU bus cycle acknowledge, VPA for peripheral and
 * interrupt acknowledge cycles, DTACK for memory cycles
 * with the turbo mode delay
 */

`timescale 1ns/1ps

module bus_ack_decoder (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cpu_reset_n,
	input  logic                    status_turbo,
	input  logic                    cpu_as_n,
	input  logic [2:0]              cpu_fc,
	input  mac_glue_pkg::cpu_addr_t cpu_addr,
	input  logic                    cpu_bus_control,
	input  logic                    select_rom,
	input  logic                    select_ram,
	output logic                    cpu_vpa_n,
	output logic                    cpu_dtack_n
);
	import mac_glue_pkg::*;

	logic io_space;
	logic bus_control_d;
	logic bus_control_rise;
	logic turbo_dtack_en;

	assign io_space         = (cpu_addr[23:21] == IO_SPACE_TAG);
	assign bus_control_rise = cpu_bus_control && !bus_control_d;

	// ==========================================================
	// Turbo DTACK enable
	// ==========================================================
	// Memory cycles wait for the CPU slot, others go at once
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus_control_d  <= 1'b0;
			turbo_dtack_en <= 1'b0;
		end else begin
			bus_control_d <= cpu_bus_control;
			if (!cpu_reset_n) begin
				turbo_dtack_en <= 1'b0;
			end else if (cpu_as_n) begin
				turbo_dtack_en <= 1'b0;
			end else if (bus_control_rise || (!select_rom && !select_ram)) begin
				turbo_dtack_en <= 1'b1;
			end
		end
	end

	// ==========================================================
	// Acknowledge lines
	// ==========================================================
	assign cpu_vpa_n = !((cpu_fc == FC_INT_ACK) || (!cpu_as_n && io_space));

	// Peripheral space is answered by VPA instead
	assign cpu_dtack_n = !(!cpu_as_n && !io_space) || (status_turbo && !turbo_dtack_en);

endmodule

//--- rtl/reset_sequencer.sv
/*
 * Machine reset sequencer, merges all reset sources and
 * holds n_reset low for a counted time on the 8 MHz strobe
 */

`timescale 1ns/1ps

module reset_sequencer #(
	parameter int RESET_CNT_W = 16
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic clk8_en_p,
	input  logic pll_locked,
	input  logic status_reset,
	input  logic user_button,
	input  logic status_mem,
	input  logic cpu_reset_out_n,
	output logic n_reset
);
	logic [RESET_CNT_W-1:0] rst_cnt;
	logic                   last_mem;
	logic                   rst_source;

	// A memory size change counts as a source too
	assign rst_source = !pll_locked || status_reset || user_button ||
		!cpu_reset_out_n || (last_mem != status_mem);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rst_cnt  <= '1;
			n_reset  <= 1'b0;
			last_mem <= status_mem;
		end else if (clk8_en_p) begin
			last_mem <= status_mem;
			if (rst_source) begin
				rst_cnt <= '1;
				n_reset <= 1'b0;
			end else if (rst_cnt != '0) begin
				rst_cnt <= rst_cnt - 1'b1;
			end else begin
				// Hold time over
				n_reset <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/mac_glue_pkg.sv
/*
 * Shared definitions for the Mac Plus glue logic:
 * word and address types, the SDRAM word address union,
 * bus decode tags and floppy image size constants
 */

package mac_glue_pkg;

	// ==========================================================
	// Basic widths and types
	// ==========================================================
	typedef logic [15:0] mac_word_t;
	typedef logic [23:1] cpu_addr_t;
	typedef logic [21:0] mem_addr_t;

	// Drive index in the top two bits, word offset below
	typedef logic [20:0] dl_addr_t;

	// ==========================================================
	// SDRAM word address, seen by the download path or the CPU
	// ==========================================================
	typedef struct packed {
		logic [3:0] bank;
		dl_addr_t   target;
	} sdram_dl_view_t;

	typedef struct packed {
		logic [2:0]  pad;
		logic        rom;
		logic [20:0] word;
	} sdram_cpu_view_t;

	typedef union packed {
		sdram_dl_view_t  dl;
		sdram_cpu_view_t cpu;
	} sdram_addr_u;

	// Bus decode
	localparam logic [2:0] IO_SPACE_TAG = 3'b111;
	localparam logic [2:0] FC_INT_ACK   = 3'b111;

	// Downloads land right after the OS ROM
	localparam logic [3:0] DL_BANK_TAG = 4'd1;

	// Image sizes in words
	localparam int DSK_DS_WORDS = 409600;
	localparam int DSK_SS_WORDS = 204800;

	// Download slots of the two floppy drives
	localparam int IDX_INT_FLOPPY = 1;
	localparam int IDX_EXT_FLOPPY = 2;

endpackage
